//--- include/h80_defs.svh
`ifndef H80_DEFS_SVH
`define H80_DEFS_SVH

`define H80_REG_WIDTH      16
`define H80_ADDR_WIDTH     16
`define H80_INS_WIDTH      16
`define H80_NUM_REGS       16
`define H80_NUM_FLAGS      4

`define H80_FLAG_CARRY     0
`define H80_FLAG_ZERO      1
`define H80_FLAG_SIGN      2
`define H80_FLAG_OVERFLOW  3

// ins[11:9] of a bus instruction
`define H80_CMD_READ_W     3'b001
`define H80_CMD_WRITE_W    3'b011

`define H80_INS_BYTES      2

// ins[15:12] major opcodes
`define H80_OPC_SYS        4'h0
`define H80_OPC_LDI_Z      4'h1
`define H80_OPC_LDI_S      4'h2
`define H80_OPC_BUS        4'h3
`define H80_OPC_ADD        4'h8
`define H80_OPC_SUB        4'h9
`define H80_OPC_AND        4'hc
`define H80_OPC_OR         4'hd
`define H80_OPC_XOR        4'he
`define H80_OPC_CP         4'hf

`endif

//--- src/h80_pkg.sv
`include "h80_defs.svh"

package h80_pkg;

   typedef logic [`H80_REG_WIDTH-1:0] reg_t;
   typedef logic [`H80_ADDR_WIDTH-1:0] addr_t;
   typedef logic [`H80_INS_WIDTH-1:0] ins_t;
   typedef logic [$clog2(`H80_NUM_REGS)-1:0] reg_num_t;
   typedef logic [`H80_NUM_FLAGS-1:0] flags_t;  // carry, zero, sign, overflow

   typedef enum logic [3:0] {
      OP_NOP,
      OP_HALT,
      OP_LDI,     // byte immediate, already extended
      OP_LOAD,
      OP_STORE,
      OP_JP,      // conditional or not
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_CP       // flags only
   } op_e;

   typedef enum logic {
      S_FETCH_EXEC,  // fetch and execute in one cycle
      S_BUS_RW       // data access of a load or store
   } seq_state_e;

endpackage

//--- src/h80_op_if.sv
`timescale 1ns/1ns

interface h80_op_if;
   import h80_pkg::*;

   op_e        op;
   reg_num_t   dst;
   reg_t       a_val;
   reg_t       b_val;
   reg_t       imm;        // extended byte or jump-always marker
   logic [1:0] cond_flag;  // flag index for jumps
   logic       cond_true;  // jump when flag equals this

   modport decode (
      output op, dst, a_val, b_val, imm, cond_flag, cond_true
   );

   modport execute (
      input op, dst, a_val, b_val, imm, cond_flag, cond_true
   );

endinterface

//--- src/h80_decode.sv
`timescale 1ns/1ns
`include "h80_defs.svh"

module h80_decode (
   input  h80_pkg::ins_t     ins,
   output h80_pkg::reg_num_t rd_num_a,
   output h80_pkg::reg_num_t rd_num_b,
   input  h80_pkg::reg_t     rd_val_a,
   input  h80_pkg::reg_t     rd_val_b,
   h80_op_if.decode          op
);
   import h80_pkg::*;

   op_e  dec_op;
   logic jp_always;  // JP R without condition

   assign rd_num_a = ins[7:4];  // data reg of load/store, ALU a
   assign rd_num_b = ins[3:0];  // address or jump target, ALU b

   always_comb begin
      dec_op = OP_NOP;
      jp_always = 1'b0;
      case (ins[15:12])
         `H80_OPC_SYS: begin
            if (ins == 16'h0001) begin
               dec_op = OP_HALT;
            end else if (ins[11:4] == 8'h1e) begin  // 0x01er
               dec_op = OP_JP;
               jp_always = 1'b1;
            end else if (ins[11:7] == 5'b0011_0) begin  // 0x03 00ff/01ff rrrr
               dec_op = OP_JP;
            end
         end
         `H80_OPC_LDI_Z, `H80_OPC_LDI_S: dec_op = OP_LDI;
         `H80_OPC_BUS: begin
            if (!ins[8] && ins[11:9] == `H80_CMD_READ_W) begin
               dec_op = OP_LOAD;
            end else if (!ins[8] && ins[11:9] == `H80_CMD_WRITE_W) begin
               dec_op = OP_STORE;
            end
         end
         `H80_OPC_ADD: dec_op = OP_ADD;
         `H80_OPC_SUB: dec_op = OP_SUB;
         `H80_OPC_AND: dec_op = OP_AND;
         `H80_OPC_OR:  dec_op = OP_OR;
         `H80_OPC_XOR: dec_op = OP_XOR;
         `H80_OPC_CP:  dec_op = OP_CP;
         default:      dec_op = OP_NOP;  // MUL, DIV and unused
      endcase
   end

   always_comb begin
      op.op = dec_op;
      op.dst = (dec_op == OP_LOAD) ? ins[7:4] : ins[11:8];
      op.a_val = rd_val_a;
      op.b_val = rd_val_b;
      op.cond_flag = ins[5:4];
      op.cond_true = ins[6];
      if (dec_op == OP_JP) begin
         op.imm = reg_t'(jp_always);
      end else if (ins[15:12] == `H80_OPC_LDI_S) begin
         op.imm = {{(`H80_REG_WIDTH-8){ins[7]}}, ins[7:0]};
      end else begin
         op.imm = {{(`H80_REG_WIDTH-8){1'b0}}, ins[7:0]};
      end
   end

   // operand values come from the register file
   op_known_a: assert final ($isunknown(ins) ||
      !$isunknown({op.op, op.dst, op.a_val, op.b_val, op.imm}))
      else $error("decode produced unknown op for ins %h", ins);

endmodule

//--- src/h80_execute.sv
`timescale 1ns/1ns
`include "h80_defs.svh"

module h80_execute (
   input  logic              exec_en,
   h80_op_if.execute         op,
   input  h80_pkg::flags_t   flags,
   output logic              wr_en,
   output h80_pkg::reg_num_t wr_num,
   output h80_pkg::reg_t     wr_data,
   output logic              flag_en,
   output h80_pkg::flags_t   flag_val,
   output logic              jump,
   output h80_pkg::addr_t    jump_addr,
   output logic              bus_req,
   output logic              bus_write,
   output h80_pkg::addr_t    bus_addr,
   output h80_pkg::reg_t     bus_wdata,
   output logic              halt
);
   import h80_pkg::*;

   localparam int SB = `H80_REG_WIDTH - 1;  // sign bit

   logic [`H80_REG_WIDTH:0] a_ext;
   logic [`H80_REG_WIDTH:0] b_ext;
   logic [`H80_REG_WIDTH:0] res;  // top bit is carry or borrow
   logic is_arith;
   logic is_logic;
   logic cond_met;

   assign a_ext = {1'b0, op.a_val};
   assign b_ext = {1'b0, op.b_val};
   assign is_arith = op.op inside {OP_ADD, OP_SUB, OP_CP};
   assign is_logic = op.op inside {OP_AND, OP_OR, OP_XOR};

   always_comb begin
      case (op.op)
         OP_ADD:        res = a_ext + b_ext;
         OP_SUB, OP_CP: res = a_ext - b_ext;
         OP_AND:        res = a_ext & b_ext;
         OP_OR:         res = a_ext | b_ext;
         OP_XOR:        res = a_ext ^ b_ext;
         default:       res = '0;
      endcase
   end

   always_comb begin
      flag_val = '0;
      flag_val[`H80_FLAG_SIGN] = res[SB];
      flag_val[`H80_FLAG_ZERO] = (res[SB:0] == '0);
      if (is_arith) begin
         flag_val[`H80_FLAG_CARRY] = res[`H80_REG_WIDTH];
         if (op.op == OP_ADD) begin
            flag_val[`H80_FLAG_OVERFLOW] = (a_ext[SB] == b_ext[SB]) && (a_ext[SB] != res[SB]);
         end else begin
            flag_val[`H80_FLAG_OVERFLOW] = (a_ext[SB] != b_ext[SB]) && (a_ext[SB] != res[SB]);
         end
      end else begin
         flag_val[`H80_FLAG_OVERFLOW] = ~^res[SB:0];  // even parity
      end
   end

   assign cond_met = op.imm[0] || (flags[op.cond_flag] == op.cond_true);

   assign wr_en = exec_en && (is_logic || op.op inside {OP_LDI, OP_ADD, OP_SUB});
   assign wr_num = op.dst;
   assign wr_data = (op.op == OP_LDI) ? op.imm : res[SB:0];
   assign flag_en = exec_en && (is_arith || is_logic);

   assign jump = exec_en && (op.op == OP_JP) && cond_met;
   assign jump_addr = op.b_val;

   assign bus_req = exec_en && (op.op inside {OP_LOAD, OP_STORE});
   assign bus_write = (op.op == OP_STORE);
   assign bus_addr = op.b_val;  // address register
   assign bus_wdata = op.a_val;
   assign halt = exec_en && (op.op == OP_HALT);

endmodule

//--- src/h80_regfile.sv
`timescale 1ns/1ns
`include "h80_defs.svh"

module h80_regfile (
   input  logic              clk,
   input  logic              reset,
   input  h80_pkg::reg_num_t rd_num_a,
   input  h80_pkg::reg_num_t rd_num_b,
   output h80_pkg::reg_t     rd_val_a,
   output h80_pkg::reg_t     rd_val_b,
   input  logic              wr_en,
   input  h80_pkg::reg_num_t wr_num,
   input  h80_pkg::reg_t     wr_data,
   input  logic              flag_en,
   input  h80_pkg::flags_t   flag_val,
   input  logic              load_en,
   input  h80_pkg::reg_num_t load_num,
   input  h80_pkg::reg_t     load_data,
   output h80_pkg::flags_t   flags
);
   import h80_pkg::*;

   reg_t regs [`H80_NUM_REGS];

   assign rd_val_a = regs[rd_num_a];
   assign rd_val_b = regs[rd_num_b];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `H80_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_num] <= wr_data;  // end of execute cycle
      end else if (load_en) begin
         regs[load_num] <= load_data;  // end of bus cycle
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         flags <= '0;
      end else if (flag_en) begin
         flags <= flag_val;
      end
   end

   // execute writes only in fetch state, loads only in bus state
   wr_load_excl_a: assert property (@(posedge clk) disable iff (reset)
      !(wr_en && load_en))
      else $error("execute write and bus load collide");

endmodule

//--- src/h80_bus_seq.sv
`timescale 1ns/1ns
`include "h80_defs.svh"

module h80_bus_seq (
   input  logic              clk,
   input  logic              reset,
   input  logic              mem_wait,
   output h80_pkg::addr_t    mem_addr,
   output logic              mem_rd,
   output logic              mem_wr,
   output h80_pkg::reg_t     mem_wdata,
   output logic              halted,
   output logic              exec_en,
   input  logic              jump,
   input  h80_pkg::addr_t    jump_addr,
   input  logic              bus_req,
   input  logic              bus_write,
   input  h80_pkg::addr_t    bus_addr,
   input  h80_pkg::reg_t     bus_wdata,
   input  logic              halt,
   input  h80_pkg::reg_num_t op_dst,
   output logic              load_en,
   output h80_pkg::reg_num_t load_num
);
   import h80_pkg::*;

   seq_state_e state;
   addr_t      pc;
   logic       rw_write;  // pending access is a store
   addr_t      rw_addr;

   assign mem_rd = !halted && ((state == S_FETCH_EXEC) || !rw_write);
   assign mem_wr = (state == S_BUS_RW) && rw_write;
   assign mem_addr = (state == S_FETCH_EXEC) ? pc : rw_addr;
   assign exec_en = (state == S_FETCH_EXEC) && mem_rd && !mem_wait;
   assign load_en = (state == S_BUS_RW) && !rw_write && !mem_wait;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= S_FETCH_EXEC;
         pc <= '0;
         halted <= 1'b0;
         rw_write <= 1'b0;
      end else begin
         case (state)
            S_FETCH_EXEC: begin
               if (exec_en) begin
                  pc <= jump ? jump_addr : pc + addr_t'(`H80_INS_BYTES);
                  halted <= halt;  // sticky, fetch stops
                  if (bus_req) begin
                     state <= S_BUS_RW;
                     rw_write <= bus_write;
                  end
               end
            end
            S_BUS_RW: begin
               if (!mem_wait) state <= S_FETCH_EXEC;  // hold until access completes
            end
            default: state <= S_FETCH_EXEC;
         endcase
      end
   end

   // access payload, captured with the request
   always_ff @(posedge clk) begin
      if (exec_en && bus_req) begin
         rw_addr <= bus_addr;
         mem_wdata <= bus_wdata;
         load_num <= op_dst;
      end
   end

   // address and command hold while the memory stalls
   bus_hold_a: assert property (@(posedge clk) disable iff (reset)
      mem_wait |=> $stable(mem_addr) && $stable(mem_rd) && $stable(mem_wr))
      else $error("bus access changed during a wait state");

endmodule

//--- src/h80_cpu.sv
`timescale 1ns/1ns

module h80_cpu (
   input  logic           clk,
   input  logic           reset,
   output h80_pkg::addr_t mem_addr,
   output logic           mem_rd,
   output logic           mem_wr,
   output h80_pkg::reg_t  mem_wdata,
   input  h80_pkg::reg_t  mem_rdata,
   input  logic           mem_wait,
   output logic           halted
);
   import h80_pkg::*;

   reg_num_t rd_num_a;
   reg_num_t rd_num_b;
   reg_t     rd_val_a;
   reg_t     rd_val_b;
   flags_t   flags;
   logic     exec_en;
   logic     wr_en;
   reg_num_t wr_num;
   reg_t     wr_data;
   logic     flag_en;
   flags_t   flag_val;
   logic     jump;
   addr_t    jump_addr;
   logic     bus_req;
   logic     bus_write;
   addr_t    bus_addr;
   reg_t     bus_wdata;
   logic     halt;
   logic     load_en;
   reg_num_t load_num;

   h80_op_if op_bus ();  // decoded operation

   h80_decode u_decode (
      .ins      (mem_rdata),  // instruction straight off the bus
      .rd_num_a (rd_num_a),
      .rd_num_b (rd_num_b),
      .rd_val_a (rd_val_a),
      .rd_val_b (rd_val_b),
      .op       (op_bus)
   );

   h80_execute u_execute (
      .exec_en   (exec_en),
      .op        (op_bus),
      .flags     (flags),
      .wr_en     (wr_en),
      .wr_num    (wr_num),
      .wr_data   (wr_data),
      .flag_en   (flag_en),
      .flag_val  (flag_val),
      .jump      (jump),
      .jump_addr (jump_addr),
      .bus_req   (bus_req),
      .bus_write (bus_write),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .halt      (halt)
   );

   h80_regfile u_regfile (
      .clk       (clk),
      .reset     (reset),
      .rd_num_a  (rd_num_a),
      .rd_num_b  (rd_num_b),
      .rd_val_a  (rd_val_a),
      .rd_val_b  (rd_val_b),
      .wr_en     (wr_en),
      .wr_num    (wr_num),
      .wr_data   (wr_data),
      .flag_en   (flag_en),
      .flag_val  (flag_val),
      .load_en   (load_en),
      .load_num  (load_num),
      .load_data (mem_rdata),
      .flags     (flags)
   );

   h80_bus_seq u_bus_seq (
      .clk       (clk),
      .reset     (reset),
      .mem_wait  (mem_wait),
      .mem_addr  (mem_addr),
      .mem_rd    (mem_rd),
      .mem_wr    (mem_wr),
      .mem_wdata (mem_wdata),
      .halted    (halted),
      .exec_en   (exec_en),
      .jump      (jump),
      .jump_addr (jump_addr),
      .bus_req   (bus_req),
      .bus_write (bus_write),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .halt      (halt),
      .op_dst    (op_bus.dst),  // load target
      .load_en   (load_en),
      .load_num  (load_num)
   );

endmodule

//--- dv/h80_mem.sv
`timescale 1ns/1ns

module h80_mem (
   input  logic           clk,
   input  logic           wait_en,  // allow random wait states
   input  h80_pkg::addr_t addr,
   input  logic           wr,
   input  h80_pkg::reg_t  wdata,
   output h80_pkg::reg_t  rdata,
   output logic           stall
);
   import h80_pkg::*;

   reg_t words [32768];  // 64 KiB as 16-bit words
   int   seed = 32'haf04644b;

   assign rdata = words[addr[15:1]];  // valid for the current address

   initial stall = 1'b0;

   always @(negedge clk) begin
      stall <= wait_en && (($random(seed) & 3) == 0);  // roughly one cycle in four
   end

   always @(posedge clk) begin
      if (wr && !stall) begin
         words[addr[15:1]] <= wdata;
      end
   end

endmodule

//--- dv/h80_tb.sv
`timescale 1ns/1ns
`include "h80_defs.svh"

module h80_tb;
   import h80_pkg::*;

   localparam int NUM_PROGS = 2;
   localparam int RUN_CYCLES = 400;  // budget per run
   localparam int TIMEOUT_NS = 100 * (NUM_PROGS * 2 * RUN_CYCLES + 100);
   localparam int MEM_WORDS = 32768;
   localparam int SLOT_BASE = 32'h7fc0;  // word index of byte address 0xff80
   localparam logic [3:0] FLAG_OPS [3] = '{`H80_OPC_ADD, `H80_OPC_SUB, `H80_OPC_CP};
   localparam logic [3:0] ALU_OPS [5] = '{`H80_OPC_ADD, `H80_OPC_SUB, `H80_OPC_AND,
                                          `H80_OPC_OR, `H80_OPC_XOR};

   logic  clk = 1'b0;
   logic  reset = 1'b1;
   logic  wait_en = 1'b0;
   addr_t mem_addr;
   reg_t  mem_wdata;
   reg_t  mem_rdata;
   logic  mem_rd;
   logic  mem_wr;
   logic  mem_wait;
   logic  halted;
   reg_t  img [MEM_WORDS];      // program and data before the run
   reg_t  exp_mem [MEM_WORDS];  // expected image after halt
   int    pc_w;
   int    seed = 32'haf04644b;
   int    errors = 0;
   int    checks = 0;

   h80_cpu dut0 (
      .clk(clk), .reset(reset), .mem_addr(mem_addr), .mem_rd(mem_rd), .mem_wr(mem_wr),
      .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_wait(mem_wait), .halted(halted)
   );

   h80_mem mem0 (
      .clk(clk), .wait_en(wait_en), .addr(mem_addr), .wr(mem_wr),
      .wdata(mem_wdata), .rdata(mem_rdata), .stall(mem_wait)
   );

   always #50 clk = ~clk;

   task automatic emit(input ins_t ins);
      img[pc_w] = ins;
      pc_w++;
   endtask

   task automatic store_slot(input reg_num_t r, input int slot);
      emit({`H80_OPC_LDI_S, 4'd15, 8'(8'h80 + 2 * slot)});  // r15 = 0xff80 + 2*slot
      emit({`H80_OPC_BUS, `H80_CMD_WRITE_W, 1'b0, r, 4'd15});
   endtask

   task automatic build_program();
      int   base;
      reg_t v;
      for (int i = 0; i < MEM_WORDS; i++) img[i] = reg_t'(i) ^ 16'hc35a;
      pc_w = 0;
      img[SLOT_BASE] = $random(seed);
      v = $random(seed);
      img[SLOT_BASE + 1] = v;
      img[SLOT_BASE + 2] = $random(seed);
      img[SLOT_BASE + 3] = v;  // equal pair gives a zero result
      for (int i = 0; i < 4; i++) begin
         emit({`H80_OPC_LDI_S, 4'd15, 8'(8'h80 + 2 * i)});
         emit({`H80_OPC_BUS, `H80_CMD_READ_W, 1'b0, 4'(4 + i), 4'd15});  // operands r4..r7
      end
      // flag tests stay below byte address 0x100 so targets fit a byte
      for (int k = 0; k < 8; k++) begin
         base = pc_w;
         emit({`H80_OPC_LDI_Z, 4'd14, 8'(2 * (base + 6))});  // taken path
         emit({`H80_OPC_LDI_Z, 4'd13, 8'(2 * (base + 7))});  // join point
         emit({FLAG_OPS[k % 3], 4'd12, 4'(4 + k % 4), 4'(4 + (k + 1 + k / 4) % 4)});
         emit({8'h03, 1'b0, 1'(k / 4), 2'(k % 4), 4'd14});  // JPN first, then JP
         emit({`H80_OPC_LDI_Z, 4'd10, 8'h11});
         emit({8'h01, 4'he, 4'd13});
         emit({`H80_OPC_LDI_Z, 4'd10, 8'h22});
         store_slot(10, 16 + k);
      end
      emit({`H80_OPC_LDI_Z, 4'd1, 8'($random(seed)) | 8'h80});
      emit({`H80_OPC_LDI_S, 4'd2, 8'($random(seed)) | 8'h80});
      store_slot(1, 24);
      store_slot(2, 25);
      for (int k = 0; k < 5; k++) begin
         emit({ALU_OPS[k], 4'd8, 4'(4 + k % 4), 4'(4 + (k + 2) % 4)});
         store_slot(8, 26 + k);
      end
      emit({`H80_OPC_LDI_Z, 4'd9, 8'h5a});
      emit({4'ha, 4'd9, 4'd4, 4'd5});  // former MUL
      emit({4'hb, 4'd9, 4'd6, 4'd7});  // former DIV
      store_slot(9, 31);
      emit({`H80_OPC_LDI_S, 4'd15, 8'(8'h80 + 2 * 26)});
      emit({`H80_OPC_BUS, `H80_CMD_READ_W, 1'b0, 4'd11, 4'd15});  // read back ADD result
      store_slot(11, 32);
      emit(16'h0001);
      store_slot(1, 40);  // behind HALT
   endtask

   // instruction-level model, returns instructions run or 0 without HALT
   function automatic int run_reference();
      reg_t   r [16];
      flags_t fl;
      addr_t  pc;
      ins_t   ins;
      reg_t   a;
      reg_t   b;
      reg_t   res;
      int     sr;
      logic   carry;
      for (int i = 0; i < 16; i++) r[i] = '0;
      fl = '0;
      pc = '0;
      for (int n = 0; n < 10000; n++) begin
         ins = exp_mem[pc[15:1]];
         pc = pc + addr_t'(2);
         a = r[ins[7:4]];
         b = r[ins[3:0]];
         case (ins[15:12])
            4'h0: begin
               if (ins == 16'h0001) return n + 1;
               if (ins[11:4] == 8'h1e || (ins[11:7] == 5'b00110 && fl[ins[5:4]] == ins[6]))
                  pc = b;
            end
            4'h1: r[ins[11:8]] = {8'h00, ins[7:0]};
            4'h2: r[ins[11:8]] = {{8{ins[7]}}, ins[7:0]};
            4'h3: begin
               if (ins[11:8] == 4'h2) r[ins[7:4]] = exp_mem[b[15:1]];
               else if (ins[11:8] == 4'h6) exp_mem[b[15:1]] = a;
            end
            4'h8, 4'h9, 4'hf: begin
               if (ins[15:12] == 4'h8) begin
                  res = a + b;
                  sr = $signed(a) + $signed(b);
                  carry = (int'(a) + int'(b)) > 65535;
               end else begin
                  res = a - b;
                  sr = $signed(a) - $signed(b);
                  carry = a < b;  // borrow
               end
               fl = {sr > 32767 || sr < -32768, res[15], res == 0, carry};  // v s z c
               if (ins[15:12] != 4'hf) r[ins[11:8]] = res;
            end
            4'hc, 4'hd, 4'he: begin
               res = (ins[15:12] == 4'hc) ? a & b : (ins[15:12] == 4'hd) ? a | b : a ^ b;
               fl = {$countones(res) % 2 == 0, res[15], res == 0, 1'b0};
               r[ins[11:8]] = res;
            end
            default: ;
         endcase
      end
      return 0;
   endfunction

   task automatic run_program(input logic waits);
      @(negedge clk);
      reset = 1'b1;
      wait_en = waits;
      repeat (4) @(negedge clk);
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem0.words[i] = img[i];
         exp_mem[i] = img[i];
      end
      checks++;
      if (run_reference() == 0) begin
         errors++;
         $display("reference model never reached HALT");
      end
      checks++;
      if (mem_rd !== 1'b1 || mem_addr !== '0 || mem_wr !== 1'b0 || halted !== 1'b0) begin
         errors++;
         $display("mismatch at %0t: bus not in fetch from address 0 during reset", $time);
      end
      reset = 1'b0;
      while (!halted) @(negedge clk);
      repeat (10) begin
         @(negedge clk);
         checks++;
         if (mem_rd !== 1'b0 || mem_wr !== 1'b0) begin
            errors++;
            $display("mismatch at %0t: bus still active after HALT", $time);
         end
      end
      for (int i = 0; i < MEM_WORDS; i++) begin
         checks++;
         if (mem0.words[i] !== exp_mem[i]) begin
            errors++;
            $display("mismatch at %0t: address %h holds %h, expected %h (waits %0b)",
                     $time, 16'(2 * i), mem0.words[i], exp_mem[i], waits);
         end
      end
   endtask

   initial begin
      for (int p = 0; p < NUM_PROGS; p++) begin
         build_program();
         run_program(1'b0);
         run_program(1'b1);  // same image expected under wait states
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout after %0d ns, the CPU did not halt in time", TIMEOUT_NS);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

//--- src.f
+incdir+include
src/h80_pkg.sv
src/h80_op_if.sv
src/h80_decode.sv
src/h80_execute.sv
src/h80_regfile.sv
src/h80_bus_seq.sv
src/h80_cpu.sv
dv/h80_mem.sv
dv/h80_tb.sv

//--- Bender.yml
package:
  name: h80

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/h80_pkg.sv
      - src/h80_op_if.sv
      - src/h80_decode.sv
      - src/h80_execute.sv
      - src/h80_regfile.sv
      - src/h80_bus_seq.sv
      - src/h80_cpu.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/h80_mem.sv
      - dv/h80_tb.sv
